//--- include/pattern_defines.svh
`ifndef PATTERN_DEFINES_SVH
`define PATTERN_DEFINES_SVH

// Active frame size
`define PAT_H_DISP 1920
`define PAT_V_DISP 1080

// Vertical bars per line
`define PAT_BAR_COUNT 5

// Galois LFSR, right shift, taps 32/22/2/1
`define PAT_LFSR_SEED 32'hace1_2468
`define PAT_LFSR_TAPS 32'h8020_0003

// Salt and pepper levels on raw noise_r
`define PAT_PEPPER_MIN 5'd30
`define PAT_SALT_MAX 5'd2

`endif

//--- hw/video_pkg.sv
package video_pkg;

  typedef struct packed {
    logic [7:0] r;  // Most significant
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef logic [10:0] coord_t;  // Pixel or line index

  localparam rgb_t WHITE = '{r: 8'hff, g: 8'hff, b: 8'hff};
  localparam rgb_t GRAY = '{r: 8'h80, g: 8'h80, b: 8'h80};
  localparam rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};
  localparam rgb_t RED = '{r: 8'h80, g: 8'h0c, b: 8'h00};  // Dark red

endpackage

//--- hw/noise_pkg.sv
package noise_pkg;

  typedef logic signed [4:0] noise_t;

  typedef struct packed {
    logic [10:0] pad_hi;
    noise_t      noise_b;  // Bits 20:16
    logic [5:0]  pad_mid;
    noise_t      noise_g;  // Bits 9:5
    noise_t      noise_r;  // Bits 4:0
  } lfsr_fields_t;

  // LFSR state, written as one word and read as noise fields
  typedef union packed {
    logic [31:0]  raw;
    lfsr_fields_t fields;
  } lfsr_word_u;

endpackage

//--- hw/random_number_generator.sv
`timescale 1ns/1ns
`include "pattern_defines.svh"

module random_number_generator
  import noise_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       step,
  output lfsr_word_u lfsr_word
);

  logic [31:0] state;
  logic [31:0] state_shifted;

  assign state_shifted = state >> 1;

  // One shift per accepted pixel
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= `PAT_LFSR_SEED;
    end else if (step) begin
      if (state[0]) begin
        state <= state_shifted ^ `PAT_LFSR_TAPS;  // Feedback on bit shifted out
      end else begin
        state <= state_shifted;
      end
    end
  end

  assign lfsr_word.raw = state;

endmodule

//--- hw/color_bar_data_gen.sv
`timescale 1ns/1ns
`include "pattern_defines.svh"

module color_bar_data_gen
  import video_pkg::*;
  import noise_pkg::*;
#(
  parameter int H_DISP = `PAT_H_DISP,
  parameter int V_DISP = `PAT_V_DISP
) (
  input  logic       clk,
  input  logic       resetn,
  input  lfsr_word_u lfsr_word,
  output logic       noise_step,
  output rgb_t       rgb_data,
  output logic       rgb_valid,
  input  logic       rgb_ready,
  output logic       sof,
  output logic       eol,
  output coord_t     y_cnt
);

  localparam int BAR_W = H_DISP / `PAT_BAR_COUNT;

  localparam coord_t X_LAST = coord_t'(H_DISP - 1);
  localparam coord_t Y_LAST = coord_t'(V_DISP - 1);

  // Bar boundaries along the line
  localparam coord_t EDGE_1 = coord_t'(BAR_W);
  localparam coord_t EDGE_2 = coord_t'(BAR_W * 2);
  localparam coord_t EDGE_3 = coord_t'(BAR_W * 3);
  localparam coord_t EDGE_4 = coord_t'(BAR_W * 4);

  localparam logic [2:0] BAR_NOISY_GRAY = 3'd0;
  localparam logic [2:0] BAR_GRAY = 3'd1;
  localparam logic [2:0] BAR_NOISY_RED = 3'd2;
  localparam logic [2:0] BAR_RED = 3'd3;
  localparam logic [2:0] BAR_SALT_PEPPER = 3'd4;

  coord_t x_cnt;
  logic   accept;
  logic   x_last;
  logic   [2:0] bar_sel;

  logic signed [7:0] ext_r;
  logic signed [7:0] ext_g;
  logic signed [7:0] ext_b;
  logic [4:0] salt_lvl;

  assign rgb_valid = resetn;  // Always a pixel to offer outside reset
  assign accept = rgb_valid && rgb_ready;
  assign noise_step = accept;
  assign x_last = (x_cnt == X_LAST);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      x_cnt <= '0;
    end else if (accept) begin
      if (x_last) begin
        x_cnt <= '0;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      y_cnt <= '0;
    end else if (accept && x_last) begin
      if (y_cnt == Y_LAST) begin
        y_cnt <= '0;  // Frame wrap
      end else begin
        y_cnt <= y_cnt + 1'b1;
      end
    end
  end

  assign sof = (x_cnt == '0) && (y_cnt == '0);
  assign eol = x_last;

  always_comb begin
    if (x_cnt < EDGE_1) begin
      bar_sel = BAR_NOISY_GRAY;
    end else if (x_cnt < EDGE_2) begin
      bar_sel = BAR_GRAY;
    end else if (x_cnt < EDGE_3) begin
      bar_sel = BAR_NOISY_RED;
    end else if (x_cnt < EDGE_4) begin
      bar_sel = BAR_RED;
    end else begin
      bar_sel = BAR_SALT_PEPPER;  // Includes remainder columns
    end
  end

  // Signed noise widened to channel width
  assign ext_r = 8'(lfsr_word.fields.noise_r);
  assign ext_g = 8'(lfsr_word.fields.noise_g);
  assign ext_b = 8'(lfsr_word.fields.noise_b);
  assign salt_lvl = unsigned'(lfsr_word.fields.noise_r);

  always_comb begin
    rgb_data = GRAY;
    case (bar_sel)
      BAR_NOISY_GRAY: begin
        rgb_data.r = GRAY.r + ext_r;
        rgb_data.g = GRAY.g + ext_g;
        rgb_data.b = GRAY.b + ext_b;
      end
      BAR_GRAY: begin
        rgb_data = GRAY;
      end
      BAR_NOISY_RED: begin
        rgb_data.r = RED.r - ext_r;  // Red channel noise inverted
        rgb_data.g = RED.g + ext_g;
        rgb_data.b = RED.b + ext_b;
      end
      BAR_RED: begin
        rgb_data = RED;
      end
      BAR_SALT_PEPPER: begin
        if (salt_lvl >= `PAT_PEPPER_MIN) begin
          rgb_data = BLACK;
        end else if (salt_lvl <= `PAT_SALT_MAX) begin
          rgb_data = WHITE;
        end else begin
          rgb_data = GRAY;
        end
      end
      default: begin
        rgb_data = GRAY;
      end
    endcase
  end

endmodule

//--- hw/pixel_skid_buffer.sv
`timescale 1ns/1ns

module pixel_skid_buffer
  import video_pkg::*;
(
  input  logic   clk,
  input  logic   resetn,
  input  rgb_t   in_data,
  input  logic   in_sof,
  input  logic   in_eol,
  input  coord_t in_line,
  input  logic   in_valid,
  output logic   in_ready,
  output rgb_t   out_data,
  output logic   out_sof,
  output logic   out_eol,
  output coord_t out_line,
  output logic   out_valid,
  input  logic   out_ready
);

  rgb_t   spare_data;
  logic   spare_sof;
  logic   spare_eol;
  coord_t spare_line;

  logic [1:0] count;
  logic [1:0] count_next;
  logic push;
  logic pop;
  logic take_spare;
  logic take_in;
  logic spare_load;

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  assign take_spare = pop && (count == 2'd2);
  assign take_in = push && (!out_valid || out_ready);
  assign spare_load = push && out_valid && !out_ready;  // Output stalled

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 2'd1;
    end else if (pop && !push) begin
      count_next = count - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count <= 2'd0;
      out_valid <= 1'b0;
      in_ready <= 1'b1;
    end else begin
      count <= count_next;
      out_valid <= (count_next != 2'd0);
      in_ready <= (count_next != 2'd2);  // Registered, cuts path from out_ready
    end
  end

  always_ff @(posedge clk) begin
    if (take_spare) begin
      out_data <= spare_data;
      out_sof <= spare_sof;
      out_eol <= spare_eol;
      out_line <= spare_line;
    end else if (take_in) begin
      out_data <= in_data;
      out_sof <= in_sof;
      out_eol <= in_eol;
      out_line <= in_line;
    end
    if (spare_load) begin
      spare_data <= in_data;
      spare_sof <= in_sof;
      spare_eol <= in_eol;
      spare_line <= in_line;
    end
  end

endmodule

//--- hw/test_pattern_top.sv
`timescale 1ns/1ns
`include "pattern_defines.svh"

module test_pattern_top
  import video_pkg::*;
  import noise_pkg::*;
#(
  parameter int H_DISP = `PAT_H_DISP,
  parameter int V_DISP = `PAT_V_DISP
) (
  input  logic   clk,
  input  logic   resetn,
  output rgb_t   pix_data,
  output logic   pix_sof,
  output logic   pix_eol,
  output coord_t pix_line,
  output logic   pix_valid,
  input  logic   pix_ready
);

  lfsr_word_u lfsr_word;
  logic       noise_step;

  rgb_t   gen_data;
  logic   gen_sof;
  logic   gen_eol;
  coord_t gen_line;
  logic   gen_valid;
  logic   gen_ready;

  random_number_generator i_lfsr (
    .clk       (clk),
    .resetn    (resetn),
    .step      (noise_step),
    .lfsr_word (lfsr_word)
  );

  color_bar_data_gen #(
    .H_DISP (H_DISP),
    .V_DISP (V_DISP)
  ) i_gen (
    .clk        (clk),
    .resetn     (resetn),
    .lfsr_word  (lfsr_word),
    .noise_step (noise_step),
    .rgb_data   (gen_data),
    .rgb_valid  (gen_valid),
    .rgb_ready  (gen_ready),
    .sof        (gen_sof),
    .eol        (gen_eol),
    .y_cnt      (gen_line)
  );

  // Output slice toward the stream port
  pixel_skid_buffer i_skid (
    .clk       (clk),
    .resetn    (resetn),
    .in_data   (gen_data),
    .in_sof    (gen_sof),
    .in_eol    (gen_eol),
    .in_line   (gen_line),
    .in_valid  (gen_valid),
    .in_ready  (gen_ready),
    .out_data  (pix_data),
    .out_sof   (pix_sof),
    .out_eol   (pix_eol),
    .out_line  (pix_line),
    .out_valid (pix_valid),
    .out_ready (pix_ready)
  );

endmodule

//--- dv/tb_test_pattern.sv
`timescale 1ns/1ns
`include "pattern_defines.svh"

module tb_test_pattern
  import video_pkg::*;
  import noise_pkg::*;
();

  localparam int H_DISP = 40;
  localparam int V_DISP = 3;
  localparam logic [31:0] STIM_SEED = 32'hc152_4b0b;
  localparam logic [31:0] STIM_TAPS = 32'ha300_0000;

  logic   clk;
  logic   resetn;
  rgb_t   pix_data;
  logic   pix_sof;
  logic   pix_eol;
  coord_t pix_line;
  logic   pix_valid;
  logic   pix_ready;

  logic        beat;
  logic        ready_held;  // Always-ready phase active
  logic [31:0] stim_state;
  lfsr_word_u  model_word;
  int          model_x;
  int          model_y;
  int          beat_count;
  int          sof_count;
  rgb_t        exp_data;
  int          check_errors;
  int          timeout_errors;
  logic        timed_out;

  test_pattern_top #(
    .H_DISP (H_DISP),
    .V_DISP (V_DISP)
  ) i_test_pattern_top (
    .clk       (clk),
    .resetn    (resetn),
    .pix_data  (pix_data),
    .pix_sof   (pix_sof),
    .pix_eol   (pix_eol),
    .pix_line  (pix_line),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] noise_lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ `PAT_LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  function automatic logic [7:0] widen_noise(input logic [4:0] n);
    return {{3{n[4]}}, n};
  endfunction

  // Pixel for column x under LFSR state w
  function automatic rgb_t expected_pixel(input int x, input lfsr_word_u w);
    rgb_t p;
    int   bw;
    logic [4:0] raw_r;
    bw = H_DISP / `PAT_BAR_COUNT;
    raw_r = w.raw[4:0];
    p = GRAY;
    if (x < bw) begin
      p.r = GRAY.r + widen_noise(w.raw[4:0]);
      p.g = GRAY.g + widen_noise(w.raw[9:5]);
      p.b = GRAY.b + widen_noise(w.raw[20:16]);
    end else if (x < 2 * bw) begin
      p = GRAY;
    end else if (x < 3 * bw) begin
      p.r = RED.r - widen_noise(w.raw[4:0]);
      p.g = RED.g + widen_noise(w.raw[9:5]);
      p.b = RED.b + widen_noise(w.raw[20:16]);
    end else if (x < 4 * bw) begin
      p = RED;
    end else if (raw_r >= `PAT_PEPPER_MIN) begin
      p = BLACK;
    end else if (raw_r <= `PAT_SALT_MAX) begin
      p = WHITE;
    end
    return p;
  endfunction

  function automatic logic [31:0] stim_lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ STIM_TAPS;
    end
    return s >> 1;
  endfunction

  task automatic drive_random_ready();
    logic b0;
    logic b1;
    b0 = stim_state[0];
    stim_state = stim_lfsr_next(stim_state);
    b1 = stim_state[0];
    stim_state = stim_lfsr_next(stim_state);
    pix_ready = b0 | b1;  // High three cycles in four
  endtask

  assign beat = resetn && pix_valid && pix_ready;
  assign exp_data = expected_pixel(model_x, model_word);

  // Reference model advanced on each output beat
  always @(posedge clk) begin
    if (!resetn) begin
      model_word.raw <= `PAT_LFSR_SEED;
      model_x <= 0;
      model_y <= 0;
      beat_count <= 0;
      sof_count <= 0;
    end else if (beat) begin
      model_word.raw <= noise_lfsr_next(model_word.raw);
      beat_count <= beat_count + 1;
      if (pix_sof) begin
        sof_count <= sof_count + 1;
      end
      if (model_x == H_DISP - 1) begin
        model_x <= 0;
        model_y <= (model_y == V_DISP - 1) ? 0 : model_y + 1;
      end else begin
        model_x <= model_x + 1;
      end
    end
  end

  a_reset_idle: assert property (@(negedge clk) !resetn |-> !pix_valid)
    else begin
      check_errors++;
      $display("ERROR %0t: pix_valid high during reset", $time);
    end

  a_first_beat: assert property (@(posedge clk) disable iff (!resetn)
    (beat && beat_count == 0) |-> (pix_sof && pix_line == 0))
    else begin
      check_errors++;
      $display("ERROR %0t: first beat lacks sof or line 0", $time);
    end

  a_pixel: assert property (@(posedge clk) disable iff (!resetn) beat |-> pix_data == exp_data)
    else begin
      check_errors++;
      $display("ERROR %0t: pixel %h expected %h at x %0d", $time,
               $sampled(pix_data), $sampled(exp_data), $sampled(model_x));
    end

  a_hold: assert property (@(posedge clk) disable iff (!resetn)
    (pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_data) && $stable(pix_sof)
                                   && $stable(pix_eol) && $stable(pix_line)))
    else begin
      check_errors++;
      $display("ERROR %0t: output changed while stalled", $time);
    end

  a_eol: assert property (@(posedge clk) disable iff (!resetn)
    beat |-> pix_eol == (model_x == H_DISP - 1))
    else begin
      check_errors++;
      $display("ERROR %0t: eol %b at x %0d", $time, $sampled(pix_eol), $sampled(model_x));
    end

  a_line: assert property (@(posedge clk) disable iff (!resetn) beat |-> pix_line == model_y)
    else begin
      check_errors++;
      $display("ERROR %0t: line %0d expected %0d", $time, $sampled(pix_line), $sampled(model_y));
    end

  a_sof: assert property (@(posedge clk) disable iff (!resetn)
    beat |-> pix_sof == (model_x == 0 && model_y == 0))
    else begin
      check_errors++;
      $display("ERROR %0t: sof %b at x %0d y %0d", $time, $sampled(pix_sof),
               $sampled(model_x), $sampled(model_y));
    end

  a_throughput: assert property (@(posedge clk) disable iff (!resetn)
    (ready_held && pix_valid && pix_ready) |=> pix_valid)
    else begin
      check_errors++;
      $display("ERROR %0t: gap in output stream while always ready", $time);
    end

  // Random or held ready until the beat target, bounded by a cycle limit
  task automatic run_until_beats(input int target, input int limit, input logic hold);
    int cycles;
    cycles = 0;
    while (beat_count < target && !timed_out) begin
      @(posedge clk);
      #1;
      if (hold) begin
        pix_ready = 1'b1;
      end else begin
        drive_random_ready();
      end
      cycles++;
      if (cycles >= limit) begin
        timed_out = 1'b1;
        timeout_errors++;
        $display("Timed out after %0d cycles waiting for %0d output beats, saw %0d",
                 cycles, target, beat_count);
      end
    end
  endtask

  task automatic stall_output(input int cycles);
    pix_ready = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    resetn = 1'b0;
    pix_ready = 1'b0;
    ready_held = 1'b0;
    stim_state = STIM_SEED;
    check_errors = 0;
    timeout_errors = 0;
    timed_out = 1'b0;
    repeat (2) begin
      @(posedge clk);
    end
    #1;
    resetn = 1'b1;

    run_until_beats(200, 2000, 1'b0);
    for (int i = 0; i < 3; i++) begin
      if (!timed_out) begin
        stall_output(16);  // Buffer fills, generator freezes
        run_until_beats(beat_count + 20, 500, 1'b0);
      end
    end
    if (!timed_out) begin
      ready_held = 1'b1;
      run_until_beats(560, 1000, 1'b1);
      @(posedge clk);
      #1;
      ready_held = 1'b0;
      pix_ready = 1'b0;
    end

    a_frames: assert (sof_count >= 4)
      else begin
        check_errors++;
        $display("ERROR %0t: only %0d frame starts seen", $time, sof_count);
      end

    $display("Error counts: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hw/video_pkg.sv
hw/noise_pkg.sv
hw/random_number_generator.sv
hw/color_bar_data_gen.sv
hw/pixel_skid_buffer.sv
hw/test_pattern_top.sv
dv/tb_test_pattern.sv

//--- Bender.yml
package:
  name: test_pattern

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/video_pkg.sv
      - hw/noise_pkg.sv
      - hw/random_number_generator.sv
      - hw/color_bar_data_gen.sv
      - hw/pixel_skid_buffer.sv
      - hw/test_pattern_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_test_pattern.sv
